//--- hdl/vrob_pkg.sv
// Vector reorder buffer package with buffer sizes, field types and SEW/LMUL codes
package vrob_pkg;

  localparam int NUM_ENTRY = 16;
  localparam int VLEN      = 128;

  // Entry index and the same index with a wrap bit on top
  typedef logic [$clog2(NUM_ENTRY)-1:0] rob_index_t;
  typedef logic [$clog2(NUM_ENTRY):0]   rob_ptr_t;

  typedef logic [4:0] vreg_t;
  typedef logic [6:0] elem_off_t;
  typedef logic [7:0] vl_t;

  // Two 32-bit lanes with narrower elements in the low bits of each lane
  typedef logic [63:0] lane_data_t;
  typedef logic [1:0]  lane_wen_t;

  typedef logic [VLEN-1:0]   entry_data_t;
  typedef logic [VLEN/8-1:0] entry_wen_t;
  typedef logic [4:0]        exc_elem_t;

  typedef logic [1:0] sew_t;
  typedef logic [2:0] lmul_t;

  localparam sew_t SEW8  = 2'b00;
  localparam sew_t SEW16 = 2'b01;
  localparam sew_t SEW32 = 2'b10;

  // vlmul encoding where 3'b100 is reserved
  localparam lmul_t LMUL1      = 3'b000;
  localparam lmul_t LMUL2      = 3'b001;
  localparam lmul_t LMUL4      = 3'b010;
  localparam lmul_t LMUL8      = 3'b011;
  localparam lmul_t LMULEIGHTH = 3'b101;
  localparam lmul_t LMULFOURTH = 3'b110;
  localparam lmul_t LMULHALF   = 3'b111;

endpackage

//--- hdl/vrob_result_if.sv
// Writeback port bundle carrying one unit's result and its located target in the buffer
interface vrob_result_if;
  import vrob_pkg::*;

  logic        ready;
  elem_off_t   woffset;
  rob_index_t  index;
  vreg_t       vd;
  sew_t        sew;
  vl_t         vl;
  lane_data_t  wdata;
  lane_wen_t   wen;
  logic        exception;
  exc_elem_t   exception_index;

  // Filled in by the entry locator
  rob_index_t                    final_index;
  vreg_t                         final_vd;
  logic [$clog2(VLEN)-1:0]       data_offset;
  logic [$clog2(VLEN/8)-1:0]     wen_offset;
  logic                          completes;

  modport locator (
    input  woffset, index, vd, sew, vl,
    output final_index, final_vd, data_offset, wen_offset, completes
  );

  modport entries (
    input ready, woffset, index, vd, sew, vl, wdata, wen, exception, exception_index,
    input final_index, final_vd, data_offset, wen_offset, completes
  );

endinterface

//--- hdl/entry_locator.sv
// Entry locator mapping a writeback element offset to its buffer entry and lane offsets
module entry_locator (
  vrob_result_if.locator res
);
  import vrob_pkg::*;

  logic [2:0] epe_log2;
  logic [1:0] byte_log2;
  logic [4:0] epe;
  elem_off_t  step;
  logic [3:0] pos;
  logic [3:0] wen_off;
  vl_t        woff_ext;
  logic       last_pair;
  logic       last_in_vl;

  // Elements per entry and bytes per element for the element width
  always_comb begin
    case (res.sew)
      SEW32: begin
        epe_log2  = 3'd2;
        byte_log2 = 2'd2;
      end
      SEW16: begin
        epe_log2  = 3'd3;
        byte_log2 = 2'd1;
      end
      default: begin
        epe_log2  = 3'd4;
        byte_log2 = 2'd0;
      end
    endcase
  end

  assign epe      = 5'd1 << epe_log2;
  assign step     = res.woffset >> epe_log2;
  assign pos      = res.woffset[3:0] & 4'(epe - 5'd1);
  assign wen_off  = pos << byte_log2;
  assign woff_ext = vl_t'(res.woffset);

  assign last_pair  = ({1'b0, pos} == epe - 5'd2);
  // A pair holding one of the last two elements below vl closes the entry early
  assign last_in_vl = (woff_ext == res.vl - vl_t'(1)) || (woff_ext == res.vl - vl_t'(2));

  assign res.final_index = res.index + rob_index_t'(step);
  assign res.final_vd    = res.vd + vreg_t'(step);
  assign res.wen_offset  = wen_off;
  assign res.data_offset = {wen_off, 3'b000};
  assign res.completes   = last_pair | last_in_vl;

endmodule

//--- hdl/rob_pointers.sv
// Head and tail pointers of the reorder buffer with group-sized allocation and full flag
module rob_pointers (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                alloc_ena,
  input  vrob_pkg::lmul_t     lmul,
  input  logic                flush,
  input  logic                commit_done,
  output vrob_pkg::rob_index_t head,
  output vrob_pkg::rob_index_t cur_tail,
  output logic                full
);
  import vrob_pkg::*;

  localparam int IW = $bits(rob_index_t);

  rob_ptr_t head_ptr;
  rob_ptr_t tail_ptr;
  rob_ptr_t tail_step;

  // Registers claimed by one instruction
  always_comb begin
    case (lmul)
      LMUL1, LMULHALF, LMULFOURTH, LMULEIGHTH: tail_step = rob_ptr_t'(1);
      LMUL2:   tail_step = rob_ptr_t'(2);
      LMUL4:   tail_step = rob_ptr_t'(4);
      LMUL8:   tail_step = rob_ptr_t'(8);
      default: tail_step = '0;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head_ptr <= '0;
      tail_ptr <= '0;
    end else if (flush) begin
      head_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      if (commit_done) begin
        head_ptr <= head_ptr + rob_ptr_t'(1);
      end
      if (alloc_ena) begin
        tail_ptr <= tail_ptr + tail_step;
      end
    end
  end

  assign head     = head_ptr[IW-1:0];
  assign cur_tail = tail_ptr[IW-1:0];

  // Same index on different laps means every entry is reserved
  assign full = (head_ptr[IW-1:0] == tail_ptr[IW-1:0]) && (head_ptr[IW] != tail_ptr[IW]);

endmodule

//--- hdl/rob_entries.sv
// Reorder buffer entry array merging writebacks and presenting the head entry for commit
module rob_entries (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  flush,
  input  logic                  commit_ena,
  input  vrob_pkg::rob_index_t  head,
  vrob_result_if.entries        res_a,
  vrob_result_if.entries        res_ls,
  output logic                  commit_done,
  output vrob_pkg::vreg_t       vd_final,
  output vrob_pkg::entry_data_t wdata_final,
  output vrob_pkg::entry_wen_t  wen_final,
  output logic                  rv32v_exception
);
  import vrob_pkg::*;

  entry_data_t data_q    [NUM_ENTRY];
  entry_wen_t  wen_q     [NUM_ENTRY];
  vreg_t       vd_q      [NUM_ENTRY];
  sew_t        sew_q     [NUM_ENTRY];
  logic        valid_q   [NUM_ENTRY];
  logic        exc_q     [NUM_ENTRY];
  exc_elem_t   exc_idx_q [NUM_ENTRY];

  entry_data_t data_n    [NUM_ENTRY];
  entry_wen_t  wen_n     [NUM_ENTRY];
  vreg_t       vd_n      [NUM_ENTRY];
  sew_t        sew_n     [NUM_ENTRY];
  logic        valid_n   [NUM_ENTRY];
  logic        exc_n     [NUM_ENTRY];
  exc_elem_t   exc_idx_n [NUM_ENTRY];

  // Port 0 is the arithmetic unit, port 1 the load-store unit
  logic        port_ready   [2];
  rob_index_t  port_index   [2];
  vreg_t       port_vd      [2];
  sew_t        port_sew     [2];
  logic        port_done    [2];
  logic        port_exc     [2];
  exc_elem_t   port_exc_idx [2];
  entry_data_t port_data    [2];
  entry_data_t port_bmask   [2];
  entry_wen_t  port_wen     [2];
  entry_wen_t  port_wmask   [2];

  logic [3:0]  exc_byte;

  // Pack the two lanes down to the element width
  function automatic entry_data_t pair_data(lane_data_t wdata, sew_t sew);
    case (sew)
      SEW32:   pair_data = entry_data_t'(wdata);
      SEW16:   pair_data = entry_data_t'({wdata[47:32], wdata[15:0]});
      default: pair_data = entry_data_t'({wdata[39:32], wdata[7:0]});
    endcase
  endfunction

  function automatic entry_wen_t pair_wen(lane_wen_t wen, sew_t sew);
    case (sew)
      SEW32:   pair_wen = entry_wen_t'({{4{wen[1]}}, {4{wen[0]}}});
      SEW16:   pair_wen = entry_wen_t'({{2{wen[1]}}, {2{wen[0]}}});
      default: pair_wen = entry_wen_t'(wen);
    endcase
  endfunction

  function automatic entry_data_t byte_bits(entry_wen_t bytes);
    entry_data_t bits;
    for (int b = 0; b < VLEN / 8; b++) begin
      bits[b*8 +: 8] = {8{bytes[b]}};
    end
    return bits;
  endfunction

  assign port_ready[0]   = res_a.ready;
  assign port_index[0]   = res_a.final_index;
  assign port_vd[0]      = res_a.final_vd;
  assign port_sew[0]     = res_a.sew;
  assign port_done[0]    = res_a.completes;
  assign port_exc[0]     = res_a.exception;
  assign port_exc_idx[0] = res_a.exception_index;
  assign port_data[0]    = pair_data(res_a.wdata, res_a.sew) << res_a.data_offset;
  assign port_wen[0]     = pair_wen(res_a.wen, res_a.sew) << res_a.wen_offset;
  assign port_wmask[0]   = pair_wen(2'b11, res_a.sew) << res_a.wen_offset;
  assign port_bmask[0]   = byte_bits(port_wmask[0]);

  assign port_ready[1]   = res_ls.ready;
  assign port_index[1]   = res_ls.final_index;
  assign port_vd[1]      = res_ls.final_vd;
  assign port_sew[1]     = res_ls.sew;
  assign port_done[1]    = res_ls.completes;
  assign port_exc[1]     = res_ls.exception;
  assign port_exc_idx[1] = res_ls.exception_index;
  assign port_data[1]    = pair_data(res_ls.wdata, res_ls.sew) << res_ls.data_offset;
  assign port_wen[1]     = pair_wen(res_ls.wen, res_ls.sew) << res_ls.wen_offset;
  assign port_wmask[1]   = pair_wen(2'b11, res_ls.sew) << res_ls.wen_offset;
  assign port_bmask[1]   = byte_bits(port_wmask[1]);

  always_comb begin
    data_n    = data_q;
    wen_n     = wen_q;
    vd_n      = vd_q;
    sew_n     = sew_q;
    valid_n   = valid_q;
    exc_n     = exc_q;
    exc_idx_n = exc_idx_q;
    if (commit_done) begin
      valid_n[head] = 1'b0;
      exc_n[head]   = 1'b0;
      wen_n[head]   = '0;
    end
    for (int p = 0; p < 2; p++) begin
      if (port_ready[p]) begin
        data_n[port_index[p]]  = (data_n[port_index[p]] & ~port_bmask[p]) | port_data[p];
        wen_n[port_index[p]]   = (wen_n[port_index[p]] & ~port_wmask[p]) | port_wen[p];
        vd_n[port_index[p]]    = port_vd[p];
        sew_n[port_index[p]]   = port_sew[p];
        valid_n[port_index[p]] = valid_n[port_index[p]] | port_done[p];
        // Only the first faulting element of an entry is kept
        if (port_exc[p] && !exc_n[port_index[p]]) begin
          exc_idx_n[port_index[p]] = port_exc_idx[p];
        end
        exc_n[port_index[p]] = exc_n[port_index[p]] | port_exc[p];
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < NUM_ENTRY; i++) begin
        valid_q[i] <= 1'b0;
        exc_q[i]   <= 1'b0;
        wen_q[i]   <= '0;
      end
    end else if (flush) begin
      for (int i = 0; i < NUM_ENTRY; i++) begin
        valid_q[i] <= 1'b0;
        exc_q[i]   <= 1'b0;
        wen_q[i]   <= '0;
      end
    end else begin
      valid_q <= valid_n;
      exc_q   <= exc_n;
      wen_q   <= wen_n;
    end
  end

  always_ff @(posedge CLK) begin
    data_q    <= data_n;
    vd_q      <= vd_n;
    sew_q     <= sew_n;
    exc_idx_q <= exc_idx_n;
  end

  // Byte offset of the faulting element inside the head entry
  always_comb begin
    case (sew_q[head])
      SEW32:   exc_byte = {exc_idx_q[head][1:0], 2'b00};
      SEW16:   exc_byte = {exc_idx_q[head][2:0], 1'b0};
      default: exc_byte = exc_idx_q[head][3:0];
    endcase
  end

  assign commit_done     = valid_q[head] & commit_ena;
  assign rv32v_exception = exc_q[head] & commit_ena;
  assign vd_final        = vd_q[head];
  assign wdata_final     = data_q[head];
  assign wen_final       = rv32v_exception ? (wen_q[head] & ~(entry_wen_t'('1) << exc_byte))
                                           : wen_q[head];

endmodule

//--- hdl/vector_rob.sv
// Vector unit reorder buffer retiring out-of-order results to the register file in order
module vector_rob (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  alloc_ena,
  input  vrob_pkg::lmul_t       lmul,
  input  logic                  branch_mispredict,
  input  logic                  scalar_exception,
  input  logic                  commit_ena,
  // Arithmetic unit writeback
  input  logic                  ready_a,
  input  vrob_pkg::elem_off_t   woffset_a,
  input  vrob_pkg::rob_index_t  index_a,
  input  vrob_pkg::vreg_t       vd_a,
  input  vrob_pkg::sew_t        sew_a,
  input  vrob_pkg::vl_t         vl_a,
  input  vrob_pkg::lane_data_t  wdata_a,
  input  vrob_pkg::lane_wen_t   wen_a,
  input  logic                  exception_a,
  input  vrob_pkg::exc_elem_t   exception_index_a,
  // Load-store unit writeback
  input  logic                  ready_ls,
  input  vrob_pkg::elem_off_t   woffset_ls,
  input  vrob_pkg::rob_index_t  index_ls,
  input  vrob_pkg::vreg_t       vd_ls,
  input  vrob_pkg::sew_t        sew_ls,
  input  vrob_pkg::vl_t         vl_ls,
  input  vrob_pkg::lane_data_t  wdata_ls,
  input  vrob_pkg::lane_wen_t   wen_ls,
  input  logic                  exception_ls,
  input  vrob_pkg::exc_elem_t   exception_index_ls,
  output vrob_pkg::rob_index_t  cur_tail,
  output logic                  full,
  output logic                  commit_done,
  output vrob_pkg::vreg_t       vd_final,
  output vrob_pkg::entry_data_t wdata_final,
  output vrob_pkg::entry_wen_t  wen_final,
  output logic                  rv32v_exception
);

  logic                 flush;
  vrob_pkg::rob_index_t head;

  vrob_result_if res_a ();
  vrob_result_if res_ls ();

  assign flush = branch_mispredict | scalar_exception;

  assign res_a.ready           = ready_a;
  assign res_a.woffset         = woffset_a;
  assign res_a.index           = index_a;
  assign res_a.vd              = vd_a;
  assign res_a.sew             = sew_a;
  assign res_a.vl              = vl_a;
  assign res_a.wdata           = wdata_a;
  assign res_a.wen             = wen_a;
  assign res_a.exception       = exception_a;
  assign res_a.exception_index = exception_index_a;

  assign res_ls.ready           = ready_ls;
  assign res_ls.woffset         = woffset_ls;
  assign res_ls.index           = index_ls;
  assign res_ls.vd              = vd_ls;
  assign res_ls.sew             = sew_ls;
  assign res_ls.vl              = vl_ls;
  assign res_ls.wdata           = wdata_ls;
  assign res_ls.wen             = wen_ls;
  assign res_ls.exception       = exception_ls;
  assign res_ls.exception_index = exception_index_ls;

  entry_locator locator_a_i (.res(res_a.locator));
  entry_locator locator_ls_i (.res(res_ls.locator));

  rob_pointers rob_pointers_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .alloc_ena   (alloc_ena),
    .lmul        (lmul),
    .flush       (flush),
    .commit_done (commit_done),
    .head        (head),
    .cur_tail    (cur_tail),
    .full        (full)
  );

  rob_entries rob_entries_i (
    .CLK             (CLK),
    .nRST            (nRST),
    .flush           (flush),
    .commit_ena      (commit_ena),
    .head            (head),
    .res_a           (res_a.entries),
    .res_ls          (res_ls.entries),
    .commit_done     (commit_done),
    .vd_final        (vd_final),
    .wdata_final     (wdata_final),
    .wen_final       (wen_final),
    .rv32v_exception (rv32v_exception)
  );

endmodule

//--- testbench/clock_gen.sv
// Testbench clock and reset generator for the vector reorder buffer
module clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Release reset away from the rising edge
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

//--- testbench/vector_rob_tb.sv
// Trace-driven testbench for the vector reorder buffer with commit checks and watchdog
module vector_rob_tb;
  import vrob_pkg::*;

  localparam int FIELDS      = 10;
  localparam int MAX_RECORDS = 64;
  localparam int PERIOD      = 8;

  localparam logic [3:0] OP_END      = 4'd0;
  localparam logic [3:0] OP_ALLOC    = 4'd1;
  localparam logic [3:0] OP_WRITE_A  = 4'd2;
  localparam logic [3:0] OP_WRITE_LS = 4'd3;
  localparam logic [3:0] OP_COMMIT   = 4'd4;
  localparam logic [3:0] OP_FLUSH    = 4'd5;
  localparam logic [3:0] OP_TAIL     = 4'd6;
  localparam logic [3:0] OP_IDLE     = 4'd7;

  logic CLK;
  logic nRST;
  logic alloc_ena, branch_mispredict, scalar_exception, commit_ena;
  lmul_t lmul;
  logic ready_a, exception_a;
  elem_off_t woffset_a;
  rob_index_t index_a;
  vreg_t vd_a;
  sew_t sew_a;
  vl_t vl_a;
  lane_data_t wdata_a;
  lane_wen_t wen_a;
  exc_elem_t exception_index_a;
  logic ready_ls, exception_ls;
  elem_off_t woffset_ls;
  rob_index_t index_ls;
  vreg_t vd_ls;
  sew_t sew_ls;
  vl_t vl_ls;
  lane_data_t wdata_ls;
  lane_wen_t wen_ls;
  exc_elem_t exception_index_ls;
  rob_index_t cur_tail;
  logic full, commit_done, rv32v_exception;
  vreg_t vd_final;
  entry_data_t wdata_final;
  entry_wen_t wen_final;

  logic [127:0] trace_mem [FIELDS*MAX_RECORDS];
  int num_records;
  bit trace_loaded;

  clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(10)) clock_gen_i (.CLK(CLK), .nRST(nRST));

  vector_rob vector_rob_i (.*);

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  task automatic idle_inputs();
    alloc_ena = 1'b0;
    lmul = LMUL1;
    branch_mispredict = 1'b0;
    scalar_exception = 1'b0;
    commit_ena = 1'b0;
    {ready_a, woffset_a, index_a, vd_a, sew_a, vl_a} = '0;
    {wdata_a, wen_a, exception_a, exception_index_a} = '0;
    {ready_ls, woffset_ls, index_ls, vd_ls, sew_ls, vl_ls} = '0;
    {wdata_ls, wen_ls, exception_ls, exception_index_ls} = '0;
  endtask

  task automatic drive_write(input bit to_ls, input int base);
    if (to_ls) begin
      ready_ls = 1'b1;
      woffset_ls = elem_off_t'(trace_mem[base+1]);
      index_ls = rob_index_t'(trace_mem[base+2]);
      vd_ls = vreg_t'(trace_mem[base+3]);
      sew_ls = sew_t'(trace_mem[base+4]);
      vl_ls = vl_t'(trace_mem[base+5]);
      wdata_ls = lane_data_t'(trace_mem[base+6]);
      wen_ls = lane_wen_t'(trace_mem[base+7]);
      exception_ls = trace_mem[base+8][0];
      exception_index_ls = exc_elem_t'(trace_mem[base+9]);
    end else begin
      ready_a = 1'b1;
      woffset_a = elem_off_t'(trace_mem[base+1]);
      index_a = rob_index_t'(trace_mem[base+2]);
      vd_a = vreg_t'(trace_mem[base+3]);
      sew_a = sew_t'(trace_mem[base+4]);
      vl_a = vl_t'(trace_mem[base+5]);
      wdata_a = lane_data_t'(trace_mem[base+6]);
      wen_a = lane_wen_t'(trace_mem[base+7]);
      exception_a = trace_mem[base+8][0];
      exception_index_a = exc_elem_t'(trace_mem[base+9]);
    end
  endtask

  // One trace record per cycle with outputs sampled a quarter period before the rising edge
  task automatic run_record(input int rec);
    int base;
    logic [3:0] op;
    string tag;
    entry_wen_t exp_wen;
    entry_data_t bytes;
    base = rec * FIELDS;
    op = trace_mem[base][3:0];
    tag = $sformatf("record %0d", rec);
    @(negedge CLK);
    idle_inputs();
    case (op)
      OP_ALLOC: begin
        alloc_ena = 1'b1;
        lmul = lmul_t'(trace_mem[base+1]);
      end
      OP_WRITE_A: drive_write(1'b0, base);
      OP_WRITE_LS: drive_write(1'b1, base);
      OP_COMMIT: begin
        commit_ena = 1'b1;
        exp_wen = entry_wen_t'(trace_mem[base+3]);
        // Only enabled bytes reach the register file
        for (int b = 0; b < VLEN / 8; b++) begin
          bytes[b*8 +: 8] = {8{exp_wen[b]}};
        end
        #(PERIOD / 4);
        check_value({tag, " commit_done"}, 128'd1, commit_done);
        check_value({tag, " vd_final"}, trace_mem[base+1], vd_final);
        check_value({tag, " wen_final"}, trace_mem[base+3], wen_final);
        check_value({tag, " wdata_final"}, trace_mem[base+2] & bytes, wdata_final & bytes);
        check_value({tag, " rv32v_exception"}, trace_mem[base+4], rv32v_exception);
      end
      OP_FLUSH: begin
        branch_mispredict = (trace_mem[base+1] == 128'd1);
        scalar_exception = (trace_mem[base+1] == 128'd2);
      end
      OP_TAIL: begin
        #(PERIOD / 4);
        check_value({tag, " cur_tail"}, trace_mem[base+1], cur_tail);
        check_value({tag, " full"}, trace_mem[base+2], full);
      end
      OP_IDLE: begin
        commit_ena = 1'b1;
        #(PERIOD / 4);
        check_value({tag, " commit_done"}, 128'd0, commit_done);
      end
      default: begin
        $display("Trace record %0d holds the unknown opcode %0h", rec, op);
        $display("Simulation FAILED");
        $fatal(1, "Bad trace opcode");
      end
    endcase
  endtask

  initial begin
    bit scanning;
    idle_inputs();
    num_records = 0;
    $readmemh("testbench/rob_trace.txt", trace_mem);
    scanning = 1'b1;
    while (scanning && num_records < MAX_RECORDS) begin
      if (trace_mem[num_records*FIELDS] === 128'(OP_END) ||
          $isunknown(trace_mem[num_records*FIELDS])) begin
        scanning = 1'b0;
      end else begin
        num_records++;
      end
    end
    if (num_records == 0) begin
      $display("The trace file is missing or holds no records");
      $display("Simulation FAILED");
      $fatal(1, "Empty trace");
    end
    trace_loaded = 1'b1;
    @(posedge nRST);
    for (int r = 0; r < num_records; r++) begin
      run_record(r);
    end
    @(negedge CLK);
    idle_inputs();
    $display("Simulation PASSED");
    $finish;
  end

  // Twenty cycles per trace record plus the reset period
  initial begin
    wait (trace_loaded);
    repeat (num_records * 20 + 10) @(posedge CLK);
    $display("The run timed out before all %0d trace records finished", num_records);
    $display("Simulation FAILED");
    $fatal(1, "Timeout");
  end

endmodule

//--- testbench/rob_trace.txt
// op f1..f9 hex. 1 alloc lmul. 2/3 write a/ls woffset index vd sew vl wdata wen exc exc_idx
// 4 commit vd wdata wen exc. 5 flush 1=mispredict 2=scalar. 6 tail full. 7 no commit. 0 end
// Reset state, allocation, full and flush of a finished entry
6 0 0 0 0 0 0 0 0 0
7 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0
6 1 0 0 0 0 0 0 0 0
1 1 0 0 0 0 0 0 0 0
6 3 0 0 0 0 0 0 0 0
1 2 0 0 0 0 0 0 0 0
6 7 0 0 0 0 0 0 0 0
1 3 0 0 0 0 0 0 0 0
6 f 0 0 0 0 0 0 0 0
1 7 0 0 0 0 0 0 0 0
6 0 1 0 0 0 0 0 0 0
2 0 0 1 2 4 0123456789abcdef 3 0 0
2 2 0 1 2 4 fedcba9876543210 3 0 0
5 1 0 0 0 0 0 0 0 0
6 0 0 0 0 0 0 0 0 0
7 0 0 0 0 0 0 0 0 0
// SEW32 entry filled by two pairs on port a
1 0 0 0 0 0 0 0 0 0
6 1 0 0 0 0 0 0 0 0
2 0 0 3 2 4 bbbbbbbbaaaaaaaa 3 0 0
2 2 0 3 2 4 ddddddddcccccccc 3 0 0
4 3 ddddddddccccccccbbbbbbbbaaaaaaaa ffff 0 0 0 0 0 0
// LMUL2 SEW8 with the second entry finished first on port ls
1 1 0 0 0 0 0 0 0 0
6 3 0 0 0 0 0 0 0 0
3 10 1 8 0 20 0000002200000011 3 0 0
3 1e 1 8 0 20 0000004400000033 3 0 0
7 0 0 0 0 0 0 0 0 0
2 0 1 8 0 20 0000006600000055 3 0 0
7 0 0 0 0 0 0 0 0 0
2 e 1 8 0 20 0000008800000077 3 0 0
4 8 88770000000000000000000000006655 c003 0 0 0 0 0 0
4 9 44330000000000000000000000002211 c003 0 0 0 0 0 0
// SEW16 with vl 6 closes at woffset 4
1 0 0 0 0 0 0 0 0 0
2 0 3 a 1 6 0000bbbb0000aaaa 3 0 0
3 2 3 a 1 6 0000dddd0000cccc 3 0 0
7 0 0 0 0 0 0 0 0 0
2 4 3 a 1 6 0000ffff0000eeee 3 0 0
4 a 00000000ffffeeeeddddccccbbbbaaaa 0fff 0 0 0 0 0 0
// SEW32 fault at element 2, a later fault at element 3 is ignored
1 0 0 0 0 0 0 0 0 0
2 0 4 c 2 4 2222222211111111 3 0 0
3 2 4 c 2 4 4444444433333333 3 1 2
2 2 4 c 2 4 4444444433333333 3 1 3
4 c 00000000000000002222222211111111 00ff 1 0 0 0 0 0
6 5 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0

//--- compile.f
hdl/vrob_pkg.sv
hdl/vrob_result_if.sv
hdl/entry_locator.sv
hdl/rob_pointers.sv
hdl/rob_entries.sv
hdl/vector_rob.sv
testbench/clock_gen.sv
testbench/vector_rob_tb.sv
